// ==== dv/tlul_bridge_checker.sv ====
`timescale 1ns/1ps

// Protocol checks on the bridge, bound into tlul_bridge_top
module tlul_bridge_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic dv_i,
    input  logic hld_i,
    input  logic rd_err_i,
    input  logic wr_err_i,
    input  logic a_valid_i,
    input  logic a_ready_i,
    input  logic pending_i,
    input  logic d_valid_i,
    input  logic intg_err_i
);

    localparam int LAT = tlul_bridge_pkg::DEV_LAT;

    int unsigned fail_cnt = 0; // Number of failed assertions

    // ------------------------------------------------------------
    // Component side
    // ------------------------------------------------------------
    hld_idle_a: assert property (@(posedge clk) disable iff (!rst_n) !dv_i |-> !hld_i)
        else begin
            fail_cnt++;
            $error("hld_o high while dv_i is low");
        end

    err_excl_a: assert property (@(posedge clk) disable iff (!rst_n) !(rd_err_i && wr_err_i))
        else begin
            fail_cnt++;
            $error("rd_err_o and wr_err_o high together");
        end

    // ------------------------------------------------------------
    // TL-UL side
    // ------------------------------------------------------------
    one_in_flight_a: assert property (@(posedge clk) disable iff (!rst_n)
                                      pending_i |-> !a_valid_i)
        else begin
            fail_cnt++;
            $error("a_valid raised with a transaction pending");
        end

    intg_a: assert property (@(posedge clk) disable iff (!rst_n) !intg_err_i)
        else begin
            fail_cnt++;
            $error("Device saw an integrity mismatch");
        end

    // D beat exactly LAT cycles after the A handshake, and never otherwise
    d_lat_a: assert property (@(posedge clk) disable iff (!rst_n)
                              d_valid_i == $past(a_valid_i && a_ready_i, LAT))
        else begin
            fail_cnt++;
            $error("d_valid not LAT cycles after A handshake");
        end

endmodule

bind tlul_bridge_top tlul_bridge_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .dv_i       (dv_i),
    .hld_i      (hld_o),
    .rd_err_i   (rd_err_o),
    .wr_err_i   (wr_err_o),
    .a_valid_i  (a_valid),
    .a_ready_i  (a_ready),
    .pending_i  (u_shim.pending_q),
    .d_valid_i  (d_valid),
    .intg_err_i (u_dev.intg_err_q)
);

// ==== dv/tlul_bridge_tb.sv ====
`timescale 1ns/1ps

module tlul_bridge_tb;

    localparam int RAND_N     = 200;
    localparam int TOTAL_ACC  = 16 + 8 + 6 + 21 + RAND_N; // Directed plus random accesses
    localparam int MAX_CYCLES = 3 * TOTAL_ACC * 2 + 50;   // 3 cycles per access, 2x margin

    logic                                       clk = 1'b0;
    logic                                       rst_n;
    logic                                       dv_i;
    logic [tlul_bridge_pkg::ADDR_W-1:0]         addr_i;
    logic                                       write_i;
    logic [tlul_bridge_pkg::SRC_W-1:0]          id_i;
    logic [tlul_bridge_pkg::DATA_W-1:0]         wdata_i;
    logic [tlul_bridge_pkg::BYTE_N-1:0]         wstrb_i;
    logic [tlul_bridge_pkg::SIZE_W-1:0]         size_i;
    logic [tlul_bridge_pkg::DATA_W-1:0]         rdata_o;
    logic                                       hld_o;
    logic                                       rd_err_o;
    logic                                       wr_err_o;

    logic [31:0] ref_mem [tlul_bridge_pkg::MEM_WORDS]; // Reference memory model
    string       test_name;
    int          test_errs;
    int          tests_passed;
    int          tests_failed;
    int          cycle_cnt = 0;
    integer      seed;

    always #2 clk = ~clk; // 4 ns period

    tlul_bridge_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .addr_i   (addr_i),
        .write_i  (write_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o)
    );

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %08h, actual %08h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    // Byte lanes with strobe set take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    // One access, held until the completing cycle, checked against the model
    task automatic run_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic id);
        logic                               in_range;
        int unsigned                        idx;
        logic [31:0]                        exp_rdata;
        @(posedge clk);
        dv_i    <= 1'b1;
        write_i <= wr;
        addr_i  <= addr;
        wdata_i <= data;
        wstrb_i <= strb;
        id_i    <= id;
        size_i  <= 3'd2;             // Full word
        do begin
            @(negedge clk);          // Outputs settled mid-cycle
        end while (hld_o);
        in_range = (addr < 32'(tlul_bridge_pkg::MEM_BYTES));
        idx      = addr / 4;         // Word holding this byte address
        if (wr) begin
            check_value("rdata_o", 32'd0, rdata_o);        // Put answers without data
            check_value("rd_err_o", 32'd0, {31'b0, rd_err_o});
            check_value("wr_err_o", {31'b0, ~in_range}, {31'b0, wr_err_o});
            if (in_range) ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
        end else begin
            exp_rdata = in_range ? ref_mem[idx] : 32'd0;
            check_value("rdata_o", exp_rdata, rdata_o);
            check_value("rd_err_o", {31'b0, ~in_range}, {31'b0, rd_err_o});
            check_value("wr_err_o", 32'd0, {31'b0, wr_err_o});
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        dv_i    <= 1'b0;
        write_i <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        release_bus();
        if (test_errs == 0) begin
            tests_passed++;
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, test_errs);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        logic [31:0] rnd;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        int unsigned chk_fails;
        seed         = 38;
        tests_passed = 0;
        tests_failed = 0;
        rst_n   = 1'b0;
        dv_i    = 1'b0;
        addr_i  = '0;
        write_i = 1'b0;
        id_i    = '0;
        wdata_i = '0;
        wstrb_i = '0;
        size_i  = '0;
        for (int w = 0; w < tlul_bridge_pkg::MEM_WORDS; w++) ref_mem[w] = 32'd0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_state");
        @(negedge clk);
        check_value("hld_o", 32'd0, {31'b0, hld_o});
        check_value("rd_err_o", 32'd0, {31'b0, rd_err_o});
        check_value("wr_err_o", 32'd0, {31'b0, wr_err_o});
        for (int w = 0; w < 16; w++) run_access(1'b0, 32'(w * 4), 32'd0, 4'hf, 1'b0);
        finish_test();

        start_test("full_write_read");
        run_access(1'b1, 32'h00, 32'hdeadbeef, 4'hf, 1'b0);
        run_access(1'b1, 32'h0c, 32'h12345678, 4'hf, 1'b1);
        run_access(1'b1, 32'h24, 32'ha5a55a5a, 4'hf, 1'b0);
        run_access(1'b1, 32'h3c, 32'hffff0001, 4'hf, 1'b1);
        run_access(1'b0, 32'h00, 32'd0, 4'hf, 1'b1);
        run_access(1'b0, 32'h0c, 32'd0, 4'hf, 1'b0);
        run_access(1'b0, 32'h24, 32'd0, 4'hf, 1'b1);
        run_access(1'b0, 32'h3c, 32'd0, 4'hf, 1'b0);
        finish_test();

        start_test("partial_merge");
        run_access(1'b1, 32'h14, 32'h11223344, 4'hf, 1'b0);
        run_access(1'b1, 32'h14, 32'haabbccdd, 4'h5, 1'b0); // Bytes 0 and 2 only
        run_access(1'b0, 32'h14, 32'd0, 4'hf, 1'b0);
        run_access(1'b1, 32'h31, 32'hcafef00d, 4'hf, 1'b1); // Unaligned, same word 12
        run_access(1'b1, 32'h32, 32'h01234567, 4'h5, 1'b1);
        run_access(1'b0, 32'h33, 32'd0, 4'hf, 1'b1);
        finish_test();

        start_test("out_of_range");
        run_access(1'b1, 32'h40, 32'h0badf00d, 4'hf, 1'b0);
        run_access(1'b1, 32'h44, 32'h55555555, 4'h3, 1'b1);
        run_access(1'b1, 32'hfffffffc, 32'h77777777, 4'hf, 1'b0);
        run_access(1'b0, 32'h40, 32'd0, 4'hf, 1'b1);
        run_access(1'b0, 32'h47, 32'd0, 4'hf, 1'b0);
        for (int w = 0; w < 16; w++) run_access(1'b0, 32'(w * 4), 32'd0, 4'hf, 1'b0);
        finish_test();

        start_test("random_traffic");
        for (int n = 0; n < RAND_N; n++) begin
            rnd    = $random(seed);
            addr_v = $unsigned($random(seed)) % 32'd72; // Slightly past the top word
            data_v = $random(seed);
            run_access(rnd[0], addr_v, data_v, rnd[4:1], rnd[5]);
        end
        finish_test();

        chk_fails = uut.u_checker.fail_cnt;
        if (chk_fails != 0) $display("Bound checker reported %0d assertion failures", chk_fails);
        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && chk_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== logic/sub_to_tlul.sv ====
`timescale 1ns/1ps

// Component port to TL-UL host shim
// One beat per access, one transaction in flight
module sub_to_tlul (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Component side
    input  logic                                 dv_i,
    input  logic [tlul_bridge_pkg::ADDR_W-1:0]   addr_i,   // Byte address
    input  logic                                 write_i,
    input  logic [tlul_bridge_pkg::SRC_W-1:0]    id_i,
    input  logic [tlul_bridge_pkg::DATA_W-1:0]   wdata_i,
    input  logic [tlul_bridge_pkg::BYTE_N-1:0]   wstrb_i,
    input  logic [tlul_bridge_pkg::SIZE_W-1:0]   size_i,
    output logic [tlul_bridge_pkg::DATA_W-1:0]   rdata_o,
    output logic                                 hld_o,
    output logic                                 rd_err_o,
    output logic                                 wr_err_o,

    // TL-UL A channel
    output logic                                 a_valid_o,
    output logic [tlul_bridge_pkg::OP_W-1:0]     a_opcode_o,
    output logic [2:0]                           a_param_o,
    output logic [tlul_bridge_pkg::SIZE_W-1:0]   a_size_o,
    output logic [tlul_bridge_pkg::SRC_W-1:0]    a_source_o,
    output logic [tlul_bridge_pkg::ADDR_W-1:0]   a_address_o,
    output logic [tlul_bridge_pkg::BYTE_N-1:0]   a_mask_o,
    output logic [tlul_bridge_pkg::DATA_W-1:0]   a_data_o,
    output logic [tlul_bridge_pkg::USER_W-1:0]   a_user_o,
    input  logic                                 a_ready_i,

    // TL-UL D channel
    input  logic                                 d_valid_i,
    input  logic [tlul_bridge_pkg::OP_W-1:0]     d_opcode_i,
    input  logic [tlul_bridge_pkg::SRC_W-1:0]    d_source_i,
    input  logic [tlul_bridge_pkg::DATA_W-1:0]   d_data_i,
    input  logic                                 d_error_i,
    output logic                                 d_ready_o
);

    logic                                       rdy_for_next_q; // Free to issue
    logic                                       pending_q;      // A sent, D not yet seen
    logic [tlul_bridge_pkg::OP_W-1:0]           opcode;
    logic [tlul_bridge_pkg::CMD_INTG_W-1:0]     cmd_intg;
    logic [tlul_bridge_pkg::DATA_INTG_W-1:0]    data_intg;

    // ------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_for_next_q <= 1'b1;
            pending_q      <= 1'b0;
        end else if (a_valid_o && a_ready_i) begin // A beat taken
            rdy_for_next_q <= 1'b0;
            pending_q      <= 1'b1;
        end else if (d_valid_i) begin              // Response back, slot free
            rdy_for_next_q <= 1'b1;
            pending_q      <= 1'b0;
        end
    end

    // Get for reads, full put only when every lane is written
    assign opcode = !write_i ? tlul_bridge_pkg::OP_GET :
                    (&wstrb_i) ? tlul_bridge_pkg::OP_PUT_FULL :
                                 tlul_bridge_pkg::OP_PUT_PARTIAL;

    assign a_valid_o   = dv_i & rdy_for_next_q & ~pending_q; // Same cycle as dv
    assign a_opcode_o  = opcode;
    assign a_param_o   = 3'h0;
    assign a_size_o    = size_i;
    assign a_source_o  = id_i;
    assign a_address_o = addr_i;
    assign a_mask_o    = wstrb_i;
    assign a_data_o    = wdata_i;

    tl_intg_gen u_intg_gen (
        .opcode_i    (opcode),
        .addr_i      (addr_i),
        .mask_i      (wstrb_i),
        .data_i      (wdata_i),
        .cmd_intg_o  (cmd_intg),
        .data_intg_o (data_intg)
    );

    assign a_user_o = {tlul_bridge_pkg::INSTR_DATA, cmd_intg, data_intg};

    // ------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------
    assign d_ready_o = 1'b1; // D channel never stalls

    // Data only for a matching Get response, zero otherwise
    assign rdata_o = (dv_i && d_valid_i && (d_source_i == id_i) &&
                      (d_opcode_i == tlul_bridge_pkg::D_OP_ACK_DATA)) ? d_data_i : '0;

    assign hld_o    = dv_i & ~d_valid_i;               // Release on the D beat
    assign rd_err_o = ~write_i & d_error_i & d_valid_i;
    assign wr_err_o =  write_i & d_error_i & d_valid_i;

endmodule

// ==== logic/tl_intg_gen.sv ====
`timescale 1ns/1ps

// XOR-reduction check bits for the A channel
// Shim fills a_user with these, device recomputes and compares
module tl_intg_gen (
    input  logic [tlul_bridge_pkg::OP_W-1:0]        opcode_i,
    input  logic [tlul_bridge_pkg::ADDR_W-1:0]      addr_i,
    input  logic [tlul_bridge_pkg::BYTE_N-1:0]      mask_i,
    input  logic [tlul_bridge_pkg::DATA_W-1:0]      data_i,
    output logic [tlul_bridge_pkg::CMD_INTG_W-1:0]  cmd_intg_o,
    output logic [tlul_bridge_pkg::DATA_INTG_W-1:0] data_intg_o
);

    // ------------------------------------------------------------
    // Command integrity
    // ------------------------------------------------------------
    always_comb begin
        logic [tlul_bridge_pkg::CMD_INTG_W-1:0] cmd;
        cmd = '0;
        for (int k = 0; k < tlul_bridge_pkg::CMD_INTG_W; k++) begin
            cmd[k] = ^addr_i[8*k +: 8]; // Parity of address byte k
        end
        // Bit 0 also covers opcode and mask, so a flipped op or strobe shows up
        cmd[0] = cmd[0] ^ (^opcode_i) ^ (^mask_i);
        cmd_intg_o = cmd;
    end

    // ------------------------------------------------------------
    // Data integrity
    // ------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < tlul_bridge_pkg::DATA_INTG_W; k++) begin
            data_intg_o[k] = ^data_i[8*k +: 8]; // Parity of data byte k
        end
    end

endmodule

// ==== logic/tlul_bridge_pkg.sv ====
package tlul_bridge_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int ADDR_W     = 32;             // Byte address
    localparam int DATA_W     = 32;
    localparam int BYTE_N     = DATA_W / 8;     // Strobe bits
    localparam int BYTE_OFS_W = $clog2(BYTE_N); // Byte offset, also largest legal a_size
    localparam int SIZE_W     = 3;
    localparam int SRC_W      = 1;              // Single ID, carried as source
    localparam int OP_W       = 3;

    // ------------------------------------------------------------
    // TL-UL opcodes
    // ------------------------------------------------------------
    localparam logic [OP_W-1:0] OP_GET         = 3'h4;
    localparam logic [OP_W-1:0] OP_PUT_FULL    = 3'h0;
    localparam logic [OP_W-1:0] OP_PUT_PARTIAL = 3'h1;
    localparam logic [OP_W-1:0] D_OP_ACK       = 3'h0; // Put response
    localparam logic [OP_W-1:0] D_OP_ACK_DATA  = 3'h1; // Get response

    // ------------------------------------------------------------
    // A-channel user field: {instr type, cmd intg, data intg}
    // ------------------------------------------------------------
    localparam int              INSTR_W     = 4;
    localparam logic [INSTR_W-1:0] INSTR_DATA = 4'h9; // Data access, never instruction fetch
    localparam int              CMD_INTG_W  = 4;  // One bit per address byte
    localparam int              DATA_INTG_W = 4;  // One bit per data byte
    localparam int              USER_W      = INSTR_W + CMD_INTG_W + DATA_INTG_W;

    // ------------------------------------------------------------
    // Device
    // ------------------------------------------------------------
    localparam int MEM_WORDS = 16;
    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int MEM_BYTES = MEM_WORDS * BYTE_N; // First out-of-range byte address
    localparam int DEV_LAT   = 2;                  // A accept to D beat, in cycles

endpackage

// ==== logic/tlul_bridge_top.sv ====
`timescale 1ns/1ps

// Component port -> shim -> TL-UL -> memory device
module tlul_bridge_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 dv_i,
    input  logic [tlul_bridge_pkg::ADDR_W-1:0]   addr_i,
    input  logic                                 write_i,
    input  logic [tlul_bridge_pkg::SRC_W-1:0]    id_i,
    input  logic [tlul_bridge_pkg::DATA_W-1:0]   wdata_i,
    input  logic [tlul_bridge_pkg::BYTE_N-1:0]   wstrb_i,
    input  logic [tlul_bridge_pkg::SIZE_W-1:0]   size_i,
    output logic [tlul_bridge_pkg::DATA_W-1:0]   rdata_o,
    output logic                                 hld_o,
    output logic                                 rd_err_o,
    output logic                                 wr_err_o
);

    // ------------------------------------------------------------
    // TL-UL link
    // ------------------------------------------------------------
    logic                                 a_valid;
    logic [tlul_bridge_pkg::OP_W-1:0]     a_opcode;
    logic [2:0]                           a_param;
    logic [tlul_bridge_pkg::SIZE_W-1:0]   a_size;
    logic [tlul_bridge_pkg::SRC_W-1:0]    a_source;
    logic [tlul_bridge_pkg::ADDR_W-1:0]   a_address;
    logic [tlul_bridge_pkg::BYTE_N-1:0]   a_mask;
    logic [tlul_bridge_pkg::DATA_W-1:0]   a_data;
    logic [tlul_bridge_pkg::USER_W-1:0]   a_user;
    logic                                 a_ready;
    logic                                 d_valid;
    logic [tlul_bridge_pkg::OP_W-1:0]     d_opcode;
    logic [tlul_bridge_pkg::SRC_W-1:0]    d_source;
    logic [tlul_bridge_pkg::DATA_W-1:0]   d_data;
    logic                                 d_error;
    logic                                 d_ready;   // Tied high inside the shim

    sub_to_tlul u_shim (
        .clk         (clk),
        .rst_n       (rst_n),
        .dv_i        (dv_i),
        .addr_i      (addr_i),
        .write_i     (write_i),
        .id_i        (id_i),
        .wdata_i     (wdata_i),
        .wstrb_i     (wstrb_i),
        .size_i      (size_i),
        .rdata_o     (rdata_o),
        .hld_o       (hld_o),
        .rd_err_o    (rd_err_o),
        .wr_err_o    (wr_err_o),
        .a_valid_o   (a_valid),
        .a_opcode_o  (a_opcode),
        .a_param_o   (a_param),
        .a_size_o    (a_size),
        .a_source_o  (a_source),
        .a_address_o (a_address),
        .a_mask_o    (a_mask),
        .a_data_o    (a_data),
        .a_user_o    (a_user),
        .a_ready_i   (a_ready),
        .d_valid_i   (d_valid),
        .d_opcode_i  (d_opcode),
        .d_source_i  (d_source),
        .d_data_i    (d_data),
        .d_error_i   (d_error),
        .d_ready_o   (d_ready)
    );

    tlul_sram_device u_dev (
        .clk         (clk),
        .rst_n       (rst_n),
        .a_valid_i   (a_valid),
        .a_opcode_i  (a_opcode),
        .a_param_i   (a_param),
        .a_size_i    (a_size),
        .a_source_i  (a_source),
        .a_address_i (a_address),
        .a_mask_i    (a_mask),
        .a_data_i    (a_data),
        .a_user_i    (a_user),
        .a_ready_o   (a_ready),
        .d_valid_o   (d_valid),
        .d_opcode_o  (d_opcode),
        .d_source_o  (d_source),
        .d_data_o    (d_data),
        .d_error_o   (d_error),
        .d_ready_i   (d_ready)
    );

endmodule

// ==== logic/tlul_sram_device.sv ====
`timescale 1ns/1ps

// Small TL-UL memory target
// Checks integrity and range, answers DEV_LAT cycles after accept
module tlul_sram_device (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // A channel
    input  logic                                 a_valid_i,
    input  logic [tlul_bridge_pkg::OP_W-1:0]     a_opcode_i,
    input  logic [2:0]                           a_param_i,
    input  logic [tlul_bridge_pkg::SIZE_W-1:0]   a_size_i,
    input  logic [tlul_bridge_pkg::SRC_W-1:0]    a_source_i,
    input  logic [tlul_bridge_pkg::ADDR_W-1:0]   a_address_i,
    input  logic [tlul_bridge_pkg::BYTE_N-1:0]   a_mask_i,
    input  logic [tlul_bridge_pkg::DATA_W-1:0]   a_data_i,
    input  logic [tlul_bridge_pkg::USER_W-1:0]   a_user_i,
    output logic                                 a_ready_o,

    // D channel
    output logic                                 d_valid_o,
    output logic [tlul_bridge_pkg::OP_W-1:0]     d_opcode_o,
    output logic [tlul_bridge_pkg::SRC_W-1:0]    d_source_o,
    output logic [tlul_bridge_pkg::DATA_W-1:0]   d_data_o,
    output logic                                 d_error_o,
    input  logic                                 d_ready_i
);

    localparam int DI = tlul_bridge_pkg::DATA_INTG_W; // Data intg sits at the bottom of a_user

    logic [tlul_bridge_pkg::DATA_W-1:0]         mem_q [tlul_bridge_pkg::MEM_WORDS];
    logic [tlul_bridge_pkg::DEV_LAT-1:0]        stage_q;     // One-hot position of the response
    logic                                       rsp_get_q;
    logic [tlul_bridge_pkg::SRC_W-1:0]          rsp_src_q;
    logic [tlul_bridge_pkg::DATA_W-1:0]         rsp_data_q;
    logic                                       rsp_err_q;   // Range or protocol fault
    logic                                       intg_err_q;  // Last accepted beat failed intg
    logic                                       a_hs;
    logic                                       stall;
    logic                                       is_get;
    logic                                       proto_ok;
    logic                                       range_ok;
    logic                                       intg_ok;
    logic                                       acc_ok;
    logic [tlul_bridge_pkg::IDX_W-1:0]          idx;
    logic [tlul_bridge_pkg::CMD_INTG_W-1:0]     cmd_intg;
    logic [tlul_bridge_pkg::DATA_INTG_W-1:0]    data_intg;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------
    assign a_ready_o = ~|stage_q;          // Idle only when nothing in flight
    assign a_hs      = a_valid_i & a_ready_o;
    assign is_get    = (a_opcode_i == tlul_bridge_pkg::OP_GET);
    assign proto_ok  = (is_get || a_opcode_i == tlul_bridge_pkg::OP_PUT_FULL ||
                        a_opcode_i == tlul_bridge_pkg::OP_PUT_PARTIAL) &&
                       (a_param_i == 3'h0) &&
                       (a_size_i <= tlul_bridge_pkg::BYTE_OFS_W); // No wider than the bus
    assign range_ok  = (a_address_i < tlul_bridge_pkg::MEM_BYTES);
    assign idx       = a_address_i[tlul_bridge_pkg::BYTE_OFS_W +: tlul_bridge_pkg::IDX_W];

    tl_intg_gen u_intg_chk (
        .opcode_i    (a_opcode_i),
        .addr_i      (a_address_i),
        .mask_i      (a_mask_i),
        .data_i      (a_data_i),
        .cmd_intg_o  (cmd_intg),
        .data_intg_o (data_intg)
    );

    // Instr type, cmd and data check bits must all agree
    assign intg_ok = (a_user_i[tlul_bridge_pkg::USER_W-1 -: tlul_bridge_pkg::INSTR_W]
                          == tlul_bridge_pkg::INSTR_DATA) &&
                     (a_user_i[DI +: tlul_bridge_pkg::CMD_INTG_W] == cmd_intg) &&
                     (a_user_i[DI-1:0] == data_intg);
    assign acc_ok  = range_ok & proto_ok & intg_ok;

    // ------------------------------------------------------------
    // Response pipeline
    // ------------------------------------------------------------
    assign d_valid_o = stage_q[tlul_bridge_pkg::DEV_LAT-1];
    assign stall     = d_valid_o & ~d_ready_i; // Hold the beat until taken

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q    <= '0;
            intg_err_q <= 1'b0;
        end else begin
            if (!stall) begin
                stage_q <= {stage_q[tlul_bridge_pkg::DEV_LAT-2:0], a_hs};
            end
            if (a_hs) begin
                intg_err_q <= ~intg_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_hs) begin
            rsp_get_q  <= is_get;
            rsp_src_q  <= a_source_i;                            // Echo ID
            rsp_data_q <= (is_get && acc_ok) ? mem_q[idx] : '0; // Zero on any fault
            rsp_err_q  <= ~(range_ok & proto_ok);
        end
    end

    assign d_opcode_o = rsp_get_q ? tlul_bridge_pkg::D_OP_ACK_DATA : tlul_bridge_pkg::D_OP_ACK;
    assign d_source_o = rsp_src_q;
    assign d_data_o   = rsp_data_q;
    assign d_error_o  = rsp_err_q | intg_err_q;

    // ------------------------------------------------------------
    // Storage, byte-masked write
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < tlul_bridge_pkg::MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (a_hs && !is_get && acc_ok) begin // Faulty puts never land
            for (int b = 0; b < tlul_bridge_pkg::BYTE_N; b++) begin
                if (a_mask_i[b]) begin
                    mem_q[idx][8*b +: 8] <= a_data_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, the verdict comes from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tlul_bridge_tb \
    -f sources.f -Mdir obj_dir &&
out=$(./obj_dir/Vtlul_bridge_tb +verilator+error+limit+1000)
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "NO ERRORS" && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== sources.f ====
logic/tlul_bridge_pkg.sv
logic/tl_intg_gen.sv
logic/sub_to_tlul.sv
logic/tlul_sram_device.sv
logic/tlul_bridge_top.sv
dv/tlul_bridge_checker.sv
dv/tlul_bridge_tb.sv
